/* hw/div_defines.svh */
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// operand and result width
`define DIV_XLEN 64

// reorder buffer entries and the tag that indexes them
`define DIV_ROB_SIZE 32
`define DIV_TAG_W ($clog2(`DIV_ROB_SIZE + 1))

`define DIV_CMD_W 10
`define DIV_QUEUE_DEPTH 2

// one quotient bit per iteration
`define DIV_STEPS `DIV_XLEN

`endif

/* hw/div_pkg.sv */
`include "div_defines.svh"

package div_pkg;

  // command word as seen by the divide unit
  // upper two bits steer the divider, the rest rides along
  typedef struct packed {
    logic                   is_signed;
    logic                   want_rem;
    logic [`DIV_CMD_W-3:0]  passthru;
  } div_cmd_t;

  // result flags toward the execute-decision logic
  typedef struct packed {
    logic       div_zero;
    logic       overflow;
    logic [1:0] reserved;
  } div_flags_t;

  // issue stage control
  typedef enum logic [1:0] {
    e_waiting,
    e_busy,
    e_done
  } div_state_e;

endpackage

/* hw/div_req_if.sv */
`timescale 1ns/1ps
`include "div_defines.svh"

// one pending divide request, queue head toward the issue stage
interface div_req_if;
  import div_pkg::*;

  logic [`DIV_XLEN-1:0]  val1;
  logic [`DIV_XLEN-1:0]  val2;
  div_cmd_t              cmd;
  logic [`DIV_TAG_W-1:0] tag;
  logic                  ready;
  logic                  stall;

  // queue side presents the head entry
  modport queue_mp (
    output val1,
    output val2,
    output cmd,
    output tag,
    output ready,
    input  stall
  );

  // stage side accepts it when waiting
  modport stage_mp (
    input  val1,
    input  val2,
    input  cmd,
    input  tag,
    input  ready,
    output stall
  );

endinterface

/* hw/div_issue_queue.sv */
`timescale 1ns/1ps
`include "div_defines.svh"

module div_issue_queue (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  push_valid_i,
  input  logic [`DIV_XLEN-1:0]  push_val1_i,
  input  logic [`DIV_XLEN-1:0]  push_val2_i,
  input  div_pkg::div_cmd_t     push_cmd_i,
  input  logic [`DIV_TAG_W-1:0] push_tag_i,
  output logic                  push_ready_o,
  div_req_if.queue_mp           req
);
  import div_pkg::*;

  localparam int DEPTH = `DIV_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry storage
  logic [`DIV_XLEN-1:0]  val1_mem [DEPTH];
  logic [`DIV_XLEN-1:0]  val2_mem [DEPTH];
  div_cmd_t              cmd_mem  [DEPTH];
  logic [`DIV_TAG_W-1:0] tag_mem  [DEPTH];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             push;
  logic             pop;

  // wrap at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_r != CNT_W'(DEPTH));
  assign push         = push_valid_i & push_ready_o;
  // head leaves when the stage takes it
  assign pop          = req.ready & ~req.stall;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      if (pop) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      val1_mem[wr_ptr_r] <= push_val1_i;
      val2_mem[wr_ptr_r] <= push_val2_i;
      cmd_mem[wr_ptr_r]  <= push_cmd_i;
      tag_mem[wr_ptr_r]  <= push_tag_i;
    end
  end

  // head entry, held while stalled since only a pop moves rd_ptr_r
  assign req.ready = (count_r != '0);
  assign req.val1  = val1_mem[rd_ptr_r];
  assign req.val2  = val2_mem[rd_ptr_r];
  assign req.cmd   = cmd_mem[rd_ptr_r];
  assign req.tag   = tag_mem[rd_ptr_r];

endmodule

/* hw/div_iterative.sv */
`timescale 1ns/1ps
`include "div_defines.svh"

module div_iterative (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  input  logic                 is_signed_i,
  input  logic                 want_rem_i,
  output logic [`DIV_XLEN-1:0] result_o,
  output div_pkg::div_flags_t  flags_o,
  output logic                 done_o
);

  localparam int XLEN  = `DIV_XLEN;
  localparam int STEPS = `DIV_STEPS;
  localparam int CNT_W = $clog2(STEPS + 1);

  // control
  logic             busy_r;
  logic [CNT_W-1:0] cnt_r;
  logic             stepping;
  logic             finishing;

  // datapath
  logic [XLEN-1:0] quot_r;
  logic [XLEN-1:0] rem_r;
  logic [XLEN-1:0] divisor_r;
  logic [XLEN-1:0] dividend_r;
  logic            neg_q_r;
  logic            neg_r_r;
  logic            zero_r;
  logic            ovf_r;
  logic            want_rem_r;

  // operand preparation
  logic            dvd_neg;
  logic            dvs_neg;
  logic [XLEN-1:0] dvd_abs;
  logic [XLEN-1:0] dvs_abs;
  logic [XLEN-1:0] min_val;
  logic            zero_in;
  logic            ovf_in;

  // one restoring step
  logic [XLEN:0]   shifted;
  logic [XLEN:0]   diff;

  logic [XLEN-1:0] q_fin;
  logic [XLEN-1:0] r_fin;

  assign min_val = {1'b1, {(XLEN - 1){1'b0}}};
  assign dvd_neg = is_signed_i & dividend_i[XLEN-1];
  assign dvs_neg = is_signed_i & divisor_i[XLEN-1];
  assign dvd_abs = dvd_neg ? -dividend_i : dividend_i;
  assign dvs_abs = dvs_neg ? -divisor_i : divisor_i;
  assign zero_in = (divisor_i == '0);
  assign ovf_in  = is_signed_i & (dividend_i == min_val) & (divisor_i == '1);

  assign stepping  = busy_r & (cnt_r != CNT_W'(STEPS));
  assign finishing = busy_r & (cnt_r == CNT_W'(STEPS));

  // bring down the next dividend bit and try the subtraction
  assign shifted = {rem_r, quot_r[XLEN-1]};
  assign diff    = shifted - {1'b0, divisor_r};

  // sign restore, then RISC-V values for the two corner cases
  always_comb begin
    q_fin = neg_q_r ? -quot_r : quot_r;
    r_fin = neg_r_r ? -rem_r : rem_r;
    if (zero_r) begin
      q_fin = '1;
      r_fin = dividend_r;
    end else if (ovf_r) begin
      q_fin = dividend_r;
      r_fin = '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= finishing;
      if (start_i) begin
        busy_r <= 1'b1;
        cnt_r  <= '0;
      end else if (finishing) begin
        busy_r <= 1'b0;
      end else if (stepping) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      quot_r     <= dvd_abs;
      rem_r      <= '0;
      divisor_r  <= dvs_abs;
      dividend_r <= dividend_i;
      // quotient negative on mixed signs, remainder follows the dividend
      neg_q_r    <= dvd_neg ^ dvs_neg;
      neg_r_r    <= dvd_neg;
      zero_r     <= zero_in;
      ovf_r      <= ovf_in;
      want_rem_r <= want_rem_i;
    end else if (stepping) begin
      rem_r  <= diff[XLEN] ? shifted[XLEN-1:0] : diff[XLEN-1:0];
      quot_r <= {quot_r[XLEN-2:0], ~diff[XLEN]};
    end

    // result and flags hold until the next start
    if (finishing) begin
      result_o          <= want_rem_r ? r_fin : q_fin;
      flags_o.div_zero  <= zero_r;
      flags_o.overflow  <= ovf_r;
      flags_o.reserved  <= 2'b00;
    end
  end

endmodule

/* hw/div_issue_stage.sv */
`timescale 1ns/1ps
`include "div_defines.svh"

module div_issue_stage (
  clk_i,
  arst_n_i,
  req,
  can_go_i,
  valid_o,
  val_o,
  cmd_o,
  tag_o,
  flags_o
);
  input  logic                  clk_i;
  input  logic                  arst_n_i;
  div_req_if.stage_mp           req;
  input  logic                  can_go_i;
  output logic                  valid_o;
  output logic [`DIV_XLEN-1:0]  val_o;
  output div_pkg::div_cmd_t     cmd_o;
  output logic [`DIV_TAG_W-1:0] tag_o;
  output div_pkg::div_flags_t   flags_o;

  import div_pkg::*;

  div_state_e state_r;
  div_state_e state_n;
  logic       accept;
  logic       div_done;

  // take a request only when idle
  assign accept    = (state_r == e_waiting) & req.ready;
  assign req.stall = ~accept;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= e_waiting;
    end else begin
      state_r <= state_n;
    end
  end

  // a result taken in its done cycle skips e_done
  always_comb begin
    state_n = state_r;
    unique case (state_r)
      e_waiting: begin
        if (accept) begin
          state_n = e_busy;
        end
      end
      e_busy: begin
        if (div_done) begin
          state_n = can_go_i ? e_waiting : e_done;
        end
      end
      e_done: begin
        if (can_go_i) begin
          state_n = e_waiting;
        end
      end
      default: state_n = e_waiting;
    endcase
  end

  // valid from the done pulse until the result is taken
  assign valid_o = (state_r == e_done) | ((state_r == e_busy) & div_done);

  // tag and command follow the operation through the divider
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_o <= req.cmd;
      tag_o <= req.tag;
    end
  end

  div_iterative div_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .start_i     (accept),
    .dividend_i  (req.val1),
    .divisor_i   (req.val2),
    .is_signed_i (req.cmd.is_signed),
    .want_rem_i  (req.cmd.want_rem),
    .result_o    (val_o),
    .flags_o     (flags_o),
    .done_o      (div_done)
  );

endmodule

/* hw/div_exec_top.sv */
`timescale 1ns/1ps
`include "div_defines.svh"

module div_exec_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // issue side
  input  logic                  issue_valid_i,
  input  logic [`DIV_XLEN-1:0]  issue_val1_i,
  input  logic [`DIV_XLEN-1:0]  issue_val2_i,
  input  div_pkg::div_cmd_t     issue_cmd_i,
  input  logic [`DIV_TAG_W-1:0] issue_tag_i,
  output logic                  issue_ready_o,

  // execute-decision side
  input  logic                  exec_can_go_i,
  output logic                  exec_valid_o,
  output logic [`DIV_XLEN-1:0]  exec_val_o,
  output div_pkg::div_cmd_t     exec_cmd_o,
  output logic [`DIV_TAG_W-1:0] exec_tag_o,
  output div_pkg::div_flags_t   exec_flags_o
);

  div_req_if req_if ();

  // pending operations, in issue order
  div_issue_queue queue_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_valid_i (issue_valid_i),
    .push_val1_i  (issue_val1_i),
    .push_val2_i  (issue_val2_i),
    .push_cmd_i   (issue_cmd_i),
    .push_tag_i   (issue_tag_i),
    .push_ready_o (issue_ready_o),
    .req          (req_if.queue_mp)
  );

  // one division at a time, result held until taken
  div_issue_stage stage_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req      (req_if.stage_mp),
    .can_go_i (exec_can_go_i),
    .valid_o  (exec_valid_o),
    .val_o    (exec_val_o),
    .cmd_o    (exec_cmd_o),
    .tag_o    (exec_tag_o),
    .flags_o  (exec_flags_o)
  );

endmodule

/* test/div_exec_assert.sv */
`timescale 1ns/1ps
`include "div_defines.svh"

module div_exec_assert (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input logic                  exec_valid_i,
  input logic                  exec_can_go_i,
  input logic [`DIV_XLEN-1:0]  exec_val_i,
  input div_pkg::div_cmd_t     exec_cmd_i,
  input logic [`DIV_TAG_W-1:0] exec_tag_i,
  input div_pkg::div_flags_t   exec_flags_i,
  input logic                  head_ready_i,
  input logic [`DIV_XLEN-1:0]  head_val1_i,
  input logic [`DIV_XLEN-1:0]  head_val2_i,
  input div_pkg::div_cmd_t     head_cmd_i,
  input logic [`DIV_TAG_W-1:0] head_tag_i,
  input div_pkg::div_state_e   state_i
);
  import div_pkg::*;

  // a result that is not taken holds still
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      (exec_valid_i && !exec_can_go_i) |=>
        (exec_valid_i && $stable(exec_val_i) && $stable(exec_cmd_i)
         && $stable(exec_tag_i) && $stable(exec_flags_i))
  ) else $error("exec outputs moved while held by exec_can_go_i low");

  a_reset_idle: assert property (
    @(posedge clk_i) !arst_n_i |-> !exec_valid_i
  ) else $error("exec_valid_o high during reset");

  // a stage that is not waiting stalls the queue, so its head stays put
  a_head_held: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      (head_ready_i && state_i != e_waiting) |=>
        (head_ready_i && $stable(head_val1_i) && $stable(head_val2_i)
         && $stable(head_cmd_i) && $stable(head_tag_i))
  ) else $error("queue head moved while the issue stage was not waiting");

endmodule

bind div_exec_top div_exec_assert assert_i (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .exec_valid_i  (exec_valid_o),
  .exec_can_go_i (exec_can_go_i),
  .exec_val_i    (exec_val_o),
  .exec_cmd_i    (exec_cmd_o),
  .exec_tag_i    (exec_tag_o),
  .exec_flags_i  (exec_flags_o),
  .head_ready_i  (req_if.ready),
  .head_val1_i   (req_if.val1),
  .head_val2_i   (req_if.val2),
  .head_cmd_i    (req_if.cmd),
  .head_tag_i    (req_if.tag),
  .state_i       (stage_i.state_r)
);

/* test/div_exec_tb.sv */
`timescale 1ns/1ps
`include "div_defines.svh"

module div_exec_tb;
  import div_pkg::*;

  localparam int XLEN           = `DIV_XLEN;
  localparam int CLK_PERIOD     = 40;
  localparam int NUM_OPS        = 30;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (`DIV_STEPS + 3) * 2 + 200;
  localparam logic [15:0] LFSR_SEED = 16'd43908;
  localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN - 1){1'b0}}};

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  issue_valid_i;
  logic [XLEN-1:0]       issue_val1_i;
  logic [XLEN-1:0]       issue_val2_i;
  div_cmd_t              issue_cmd_i;
  logic [`DIV_TAG_W-1:0] issue_tag_i;
  logic                  issue_ready_o;
  logic                  exec_can_go_i;
  logic                  exec_valid_o;
  logic [XLEN-1:0]       exec_val_o;
  div_cmd_t              exec_cmd_o;
  logic [`DIV_TAG_W-1:0] exec_tag_o;
  div_flags_t            exec_flags_o;

  logic [15:0] lfsr_r = LFSR_SEED;
  int cycles       = 0;
  int sent_count   = 0;
  int recv_count   = 0;
  int issue_cycle  = 0;
  int stall_left   = 0;
  int value_errors = 0;
  int other_errors = 0;
  bit saw_full     = 1'b0;
  bit seen_first   = 1'b0;

  // expected results in issue order
  logic [XLEN-1:0]       exp_val_q[$];
  div_cmd_t              exp_cmd_q[$];
  logic [`DIV_TAG_W-1:0] exp_tag_q[$];
  div_flags_t            exp_flags_q[$];

  div_exec_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic get_bits(input int n, output logic [63:0] bits);
    int k;
    bits = '0;
    for (k = 0; k < n; k++) begin
      lfsr_r = lfsr_next(lfsr_r);
      bits = {bits[62:0], lfsr_r[0]};
    end
  endtask

  // RISC-V division rules
  function automatic logic [XLEN-1:0] div_ref(input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b,
                                              input div_cmd_t cmd,
                                              output div_flags_t flags);
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] r;
    flags = '0;
    if (b == '0) begin
      flags.div_zero = 1'b1;
      q = '1;
      r = a;
    end else if (cmd.is_signed && a == MIN_VAL && b == '1) begin
      flags.overflow = 1'b1;
      q = a;
      r = '0;
    end else if (cmd.is_signed) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return cmd.want_rem ? r : q;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  // one clock step with random stretches of back-pressure
  task automatic next_cycle();
    logic [63:0] bits;
    @(posedge clk_i);
    if (stall_left > 0) begin
      stall_left--;
      exec_can_go_i <= 1'b0;
    end else begin
      get_bits(3, bits);
      if (bits[2:0] == 3'd0) begin
        get_bits(3, bits);
        stall_left = int'(bits[2:0]);
        exec_can_go_i <= 1'b0;
      end else begin
        exec_can_go_i <= 1'b1;
      end
    end
  endtask

  initial begin : stimulus
    logic [63:0]           bits;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    div_cmd_t              cmd;
    logic [`DIV_TAG_W-1:0] tag;
    logic                  taken;
    int                    i;
    arst_n_i      <= 1'b0;
    issue_valid_i <= 1'b0;
    issue_val1_i  <= '0;
    issue_val2_i  <= '0;
    issue_cmd_i   <= '0;
    issue_tag_i   <= '0;
    exec_can_go_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_eq("exec_valid_o", 64'(0), 64'(exec_valid_o));
    check_eq("issue_ready_o", 64'(1), 64'(issue_ready_o));
    next_cycle();
    for (i = 0; i < NUM_OPS; i++) begin
      get_bits(XLEN, a);
      get_bits(XLEN, b);
      get_bits(`DIV_CMD_W, bits);
      cmd = div_cmd_t'(bits[`DIV_CMD_W-1:0]);
      get_bits(`DIV_TAG_W, bits);
      tag = bits[`DIV_TAG_W-1:0];
      get_bits(6, bits);
      // unsigned, signed, zero divisor, overflow, then fully random
      case (i % 5)
        0: begin
          cmd.is_signed = 1'b0;
          b = b >> bits[5:0];
        end
        1: begin
          cmd.is_signed = 1'b1;
          b = $signed(b) >>> bits[5:0];
        end
        2: b = '0;
        3: begin
          cmd.is_signed = 1'b1;
          a = MIN_VAL;
          b = '1;
        end
        default: b = b;
      endcase
      issue_valid_i <= 1'b1;
      issue_val1_i  <= a;
      issue_val2_i  <= b;
      issue_cmd_i   <= cmd;
      issue_tag_i   <= tag;
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk_i);
        taken = issue_ready_o;
        next_cycle();
      end
      get_bits(2, bits);
      if (bits[1:0] != 2'd0) begin
        issue_valid_i <= 1'b0;
        repeat (int'(bits[1:0])) next_cycle();
      end
    end
    issue_valid_i <= 1'b0;
    while (recv_count < NUM_OPS) begin
      next_cycle();
    end
    if (!saw_full) begin
      $display("Error: issue_ready_o never fell, the queue was never seen full");
      other_errors++;
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  always @(negedge clk_i) begin : scoreboard
    logic [XLEN-1:0] ref_val;
    div_flags_t      ref_flags;
    if (arst_n_i) begin
      // occupancy follows from the transfers seen so far
      if (sent_count - recv_count >= 3) begin
        check_eq("issue_ready_o", 64'(0), 64'(issue_ready_o));
      end else if (sent_count - recv_count <= 1) begin
        check_eq("issue_ready_o", 64'(1), 64'(issue_ready_o));
      end
      if (!issue_ready_o) begin
        saw_full = 1'b1;
      end
      if (issue_valid_i && issue_ready_o) begin
        ref_val = div_ref(issue_val1_i, issue_val2_i, issue_cmd_i, ref_flags);
        exp_val_q.push_back(ref_val);
        exp_cmd_q.push_back(issue_cmd_i);
        exp_tag_q.push_back(issue_tag_i);
        exp_flags_q.push_back(ref_flags);
        if (sent_count == 0) begin
          issue_cycle = cycles + 1;
        end
        sent_count++;
      end
      // empty path, queue edge plus the divider run
      if (exec_valid_o && !seen_first) begin
        seen_first = 1'b1;
        check_eq("first result latency", 64'(`DIV_STEPS + 2), 64'(cycles - issue_cycle));
      end
      if (exec_valid_o && exec_can_go_i) begin
        if (exp_val_q.size() == 0) begin
          $display("Error at %0t: a result was taken with no operation outstanding", $time);
          other_errors++;
        end else begin
          check_eq("exec_val_o", exp_val_q.pop_front(), exec_val_o);
          check_eq("exec_cmd_o", 64'(exp_cmd_q.pop_front()), 64'(exec_cmd_o));
          check_eq("exec_tag_o", 64'(exp_tag_q.pop_front()), 64'(exec_tag_o));
          check_eq("exec_flags_o", 64'(exp_flags_q.pop_front()), 64'(exec_flags_o));
        end
        recv_count++;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Error: timeout, only %0d of %0d results after %0d cycles",
               recv_count, NUM_OPS, cycles);
      $display("errors: %0d value mismatches, %0d other failures", value_errors,
               other_errors + 1);
      $display("Verification failed");
      $finish;
    end
  end

endmodule

/* all.f */
+incdir+hw
hw/div_pkg.sv
hw/div_req_if.sv
hw/div_issue_queue.sv
hw/div_iterative.sv
hw/div_issue_stage.sv
hw/div_exec_top.sv
test/div_exec_assert.sv
test/div_exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= div_exec_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	  echo "test FAILED"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
	  echo "test FAILED, no result line in $(LOG)"; exit 1; \
	else \
	  echo "test PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
